// ==== dv/user_io_tb.sv ====
// testbench for user_io_top, sends a table of SPI command packets and checks registers, keys and PS/2
module user_io_tb;
	import uio_pkg::*;

	typedef enum {
		CHK_STATUS, CHK_BUTSW, CHK_JOY, CHK_UNKNOWN, CHK_KEY, CHK_DRAIN, CHK_FLUSH, CHK_RELEASE
	} chk_t;

	localparam byte_t CORE_TYPE_EXP = 8'ha4;
	// the two decode packets and the first four of the burst
	localparam int MUST_PKTS = 6;
	localparam int QUIET_CYCLES = 8 * PS2_CLK_DIV;

	logic clk_sys, SPI_CLK, SPI_SS_IO, SPI_MOSI;
	logic SPI_MISO_o, key_pressed_o, key_extended_o, key_strobe_o, ps2_kbd_clk_o, ps2_kbd_data_o;
	logic [1:0] buttons_o, switches_o;
	joy_t joystick_0_o, joystick_1_o;
	status_t status_o;
	byte_t key_code_o;

	// stimulus table, payload byte i sits at bits 8*i+7:8*i
	byte_t row_cmd[$];
	int row_len[$];
	chk_t row_kind[$];
	logic [71:0] row_pay[$];

	// expected state built from the command rules
	logic [1:0] exp_buttons, exp_switches;
	joy_t exp_joy0, exp_joy1;
	status_t exp_status;
	byte_t exp_code;
	logic exp_pressed, exp_ext;
	byte_t exp_bytes[$];
	int pkt_start[$];
	int pkt_len[$];
	byte_t rx_q[$];

	int err_cnt = 0;
	int rows_ok = 0;
	int rows_bad = 0;
	int strobe_cnt = 0;
	int strobe_base = 0;
	int row_strobes = 0;
	int frame_starts = 0;
	int frame_snap = 0;
	int mon_cnt = 0;
	logic [10:0] frame_bits;
	bit mon_en = 1'b0;
	longint wd_limit = 0;

	user_io_top dut (
		.clk_sys        (clk_sys),
		.SPI_CLK        (SPI_CLK),
		.SPI_SS_IO      (SPI_SS_IO),
		.SPI_MOSI       (SPI_MOSI),
		.SPI_MISO_o     (SPI_MISO_o),
		.buttons_o      (buttons_o),
		.switches_o     (switches_o),
		.joystick_0_o   (joystick_0_o),
		.joystick_1_o   (joystick_1_o),
		.status_o       (status_o),
		.key_code_o     (key_code_o),
		.key_pressed_o  (key_pressed_o),
		.key_extended_o (key_extended_o),
		.key_strobe_o   (key_strobe_o),
		.ps2_kbd_clk_o  (ps2_kbd_clk_o),
		.ps2_kbd_data_o (ps2_kbd_data_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(negedge clk_sys) begin
		if (key_strobe_o === 1'b1) begin
			strobe_cnt++;
		end
		// an aborted frame restarts the bit count
		if (status_o[0] === 1'b1) begin
			mon_cnt = 0;
		end
	end

	// PS/2 device side, bits taken on the falling clock
	always @(negedge ps2_kbd_clk_o) begin
		if (mon_en) begin
			frame_bits[mon_cnt] = ps2_kbd_data_o;
			if (mon_cnt == 0) begin
				frame_starts++;
			end
			if (mon_cnt == 10) begin
				mon_cnt = 0;
				assert (frame_bits[0] === 1'b0 && frame_bits[10] === 1'b1 &&
					(^frame_bits[9:1]) === 1'b1) else begin
					$display("ERR %0t: bad PS/2 frame %b", $time, frame_bits);
					err_cnt++;
				end
				rx_q.push_back(frame_bits[8:1]);
			end else begin
				mon_cnt++;
			end
		end
	end

	initial begin
		wait (wd_limit > 0);
		#(wd_limit);
		$display("timeout: the run did not finish within %0d time units", wd_limit);
		$display("Simulation failed");
		$finish;
	end

	task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic add_row(input byte_t cmd, input int len, input chk_t kind, input logic [8:0] rnd,
		input logic [71:0] pay);
		int i;
		for (i = 0; i < 9; i++) begin
			if (rnd[i]) begin
				pay[8*i +: 8] = 8'($urandom);
			end
		end
		row_cmd.push_back(cmd);
		row_len.push_back(len);
		row_kind.push_back(kind);
		row_pay.push_back(pay);
	endtask

	task automatic update_model(input int r);
		logic [71:0] p;
		byte_t b;
		logic ext;
		logic brk;
		int i;
		p = row_pay[r];
		ext = 1'b0;
		brk = 1'b0;
		row_strobes = 0;
		case (row_cmd[r])
			CMD_BUT_SW: begin
				exp_buttons  = p[1:0];
				exp_switches = p[3:2];
			end
			CMD_JOY0: begin
				for (i = 0; i < 4 && i < row_len[r]; i++) begin
					exp_joy0[8*i +: 8] = p[8*i +: 8];
				end
			end
			CMD_JOY1: begin
				for (i = 0; i < 4 && i < row_len[r]; i++) begin
					exp_joy1[8*i +: 8] = p[8*i +: 8];
				end
			end
			CMD_STATUS64: begin
				for (i = 0; i < 8 && i < row_len[r]; i++) begin
					exp_status[8*i +: 8] = p[8*i +: 8];
				end
			end
			CMD_KBD: begin
				pkt_start.push_back(exp_bytes.size());
				pkt_len.push_back(row_len[r]);
				for (i = 0; i < row_len[r]; i++) begin
					b = p[8*i +: 8];
					exp_bytes.push_back(b);
					// e0 marks extended, f0 marks release, anything else ends the key
					if (b == 8'he0) begin
						ext = 1'b1;
					end else if (b == 8'hf0) begin
						brk = 1'b1;
					end else begin
						exp_code    = b;
						exp_pressed = ~brk;
						exp_ext     = ext;
						row_strobes++;
					end
				end
			end
			default: begin
			end
		endcase
	endtask

	task automatic send_byte(input byte_t b, output byte_t resp);
		int i;
		for (i = 7; i >= 0; i--) begin
			SPI_CLK  = 1'b0;
			SPI_MOSI = b[i];
			repeat (4) @(negedge clk_sys);
			// MISO moved on the previous falling SPI_CLK
			resp[i] = SPI_MISO_o;
			SPI_CLK = 1'b1;
			repeat (4) @(negedge clk_sys);
		end
	endtask

	task automatic send_row(input int r);
		logic [71:0] p;
		byte_t resp;
		int i;
		p = row_pay[r];
		SPI_SS_IO = 1'b0;
		repeat (2) @(negedge clk_sys);
		send_byte(row_cmd[r], resp);
		assert (resp === CORE_TYPE_EXP) else begin
			$display("ERR %0t: MISO during command byte %h, expected %h", $time, resp, CORE_TYPE_EXP);
			err_cnt++;
		end
		for (i = 0; i < row_len[r]; i++) begin
			send_byte(p[8*i +: 8], resp);
		end
		SPI_CLK = 1'b0;
		repeat (6) @(negedge clk_sys);
		SPI_SS_IO = 1'b1;
	endtask

	// returns once the PS/2 clock has stayed high for several periods between frames
	task automatic wait_ps2_idle();
		int quiet;
		quiet = 0;
		while (quiet < QUIET_CYCLES) begin
			@(negedge clk_sys);
			if (ps2_kbd_clk_o === 1'b1 && mon_cnt == 0) begin
				quiet++;
			end else begin
				quiet = 0;
			end
		end
	endtask

	// received bytes must be whole packets in send order, dropped packets leave no trace
	task automatic match_packets();
		int pos;
		int p;
		int k;
		bit hit;
		pos = 0;
		for (p = 0; p < pkt_len.size(); p++) begin
			hit = (pos + pkt_len[p] <= rx_q.size());
			for (k = 0; k < pkt_len[p]; k++) begin
				if (hit && rx_q[pos + k] !== exp_bytes[pkt_start[p] + k]) begin
					hit = 1'b0;
				end
			end
			if (hit) begin
				pos += pkt_len[p];
			end else begin
				assert (p >= MUST_PKTS) else begin
					$display("ERR %0t: keyboard packet %0d missing on PS/2", $time, p);
					err_cnt++;
				end
			end
		end
		assert (pos == rx_q.size()) else begin
			$display("ERR %0t: %0d PS/2 bytes match no whole packet", $time, rx_q.size() - pos);
			err_cnt++;
		end
	endtask

	task automatic check_row(input int r);
		case (row_kind[r])
			CHK_BUTSW: begin
				check_value("buttons_o", buttons_o, exp_buttons);
				check_value("switches_o", switches_o, exp_switches);
			end
			CHK_JOY: begin
				if (row_cmd[r] == CMD_JOY0) begin
					check_value("joystick_0_o", joystick_0_o, exp_joy0);
				end else begin
					check_value("joystick_1_o", joystick_1_o, exp_joy1);
				end
			end
			CHK_UNKNOWN: begin
				check_value("buttons_o", buttons_o, exp_buttons);
				check_value("switches_o", switches_o, exp_switches);
				check_value("joystick_0_o", joystick_0_o, exp_joy0);
				check_value("joystick_1_o", joystick_1_o, exp_joy1);
				check_value("status_o", status_o, exp_status);
			end
			CHK_KEY, CHK_DRAIN: begin
				check_value("key_code_o", key_code_o, exp_code);
				check_value("key_pressed_o", key_pressed_o, exp_pressed);
				check_value("key_extended_o", key_extended_o, exp_ext);
				check_value("key_strobe_o pulses", strobe_cnt - strobe_base, row_strobes);
			end
			default: begin
				check_value("status_o", status_o, exp_status);
			end
		endcase
		if (row_kind[r] == CHK_DRAIN) begin
			wait_ps2_idle();
			match_packets();
		end
		if (row_kind[r] == CHK_FLUSH) begin
			frame_snap = frame_starts;
		end
		if (row_kind[r] == CHK_RELEASE) begin
			wait_ps2_idle();
			assert (frame_starts == frame_snap) else begin
				$display("ERR %0t: %0d PS/2 frames started after the flush", $time,
					frame_starts - frame_snap);
				err_cnt++;
			end
		end
	endtask

	initial begin
		int r;
		int kbd_bytes;
		int err_before;
		SPI_SS_IO = 1'b1;
		SPI_CLK   = 1'b0;
		SPI_MOSI  = 1'b0;
		void'($urandom(32'h22546d3e));

		// first status row holds the keyboard path in reset, the second releases it
		add_row(CMD_STATUS64, 8, CHK_STATUS, 9'h000, 72'h01);
		add_row(CMD_STATUS64, 8, CHK_STATUS, 9'h0fe, 72'h00);
		add_row(CMD_BUT_SW, 2, CHK_BUTSW, 9'h003, 72'h0);
		add_row(CMD_JOY0, 5, CHK_JOY, 9'h01f, 72'h0);
		add_row(CMD_JOY1, 4, CHK_JOY, 9'h00f, 72'h0);
		add_row(8'h33, 4, CHK_UNKNOWN, 9'h00f, 72'h0);
		add_row(CMD_KBD, 1, CHK_KEY, 9'h000, 72'h1c);
		add_row(CMD_KBD, 3, CHK_KEY, 9'h000, 72'h75f0e0);
		// back to back burst that outruns the PS/2 line
		for (r = 0; r < 5; r++) begin
			add_row(CMD_KBD, 4, CHK_KEY, 9'h00f, 72'h0);
		end
		add_row(CMD_KBD, 4, CHK_DRAIN, 9'h00f, 72'h0);
		// queued bytes that the next status row throws away
		add_row(CMD_KBD, 4, CHK_KEY, 9'h00f, 72'h0);
		add_row(CMD_STATUS64, 8, CHK_FLUSH, 9'h0fe, 72'h01);
		add_row(CMD_STATUS64, 8, CHK_RELEASE, 9'h0fe, 72'h00);

		kbd_bytes = 0;
		for (r = 0; r < row_cmd.size(); r++) begin
			if (row_cmd[r] == CMD_KBD) begin
				kbd_bytes += row_len[r];
			end
		end
		wd_limit = 2 * (longint'(row_cmd.size()) * 10 * 8 * 8 * 100 +
			longint'(kbd_bytes) * 12 * 2 * PS2_CLK_DIV * 100);

		repeat (8) @(negedge clk_sys);
		for (r = 0; r < row_cmd.size(); r++) begin
			err_before  = err_cnt;
			strobe_base = strobe_cnt;
			update_model(r);
			send_row(r);
			check_row(r);
			repeat (4) @(negedge clk_sys);
			// PS/2 lines only become defined after the first flush
			if (r == 0) begin
				mon_en = 1'b1;
			end
			if (err_cnt == err_before) begin
				rows_ok++;
			end else begin
				rows_bad++;
			end
			$display("row %0d cmd %h, %0d payload bytes: %s", r, row_cmd[r], row_len[r],
				(err_cnt == err_before) ? "ok" : "FAILED");
		end

		$display("rows passed %0d, rows failed %0d, errors %0d", rows_ok, rows_bad, err_cnt);
		if (rows_bad == 0 && err_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
src/uio_pkg.sv
src/kbd_stream_if.sv
src/spi_byte_rx.sv
src/spi_sys_sync.sv
src/host_cmd_decoder.sv
src/ps2_tx_fifo.sv
src/ps2_serializer.sv
src/user_io_top.sv
dv/user_io_tb.sv

// ==== src/host_cmd_decoder.sv ====
// parses host command packets into core registers, key events and the PS/2 keyboard byte stream
module host_cmd_decoder (
	input  logic             clk_sys,
	input  logic             byte_valid_i,
	input  uio_pkg::byte_t   byte_data_i,
	input  logic             xfer_end_i,
	kbd_stream_if.producer   kbd,
	output logic [1:0]       buttons_o,
	output logic [1:0]       switches_o,
	output uio_pkg::joy_t    joystick_0_o,
	output uio_pkg::joy_t    joystick_1_o,
	output uio_pkg::status_t status_o,
	output uio_pkg::byte_t   key_code_o,
	output logic             key_pressed_o,
	output logic             key_extended_o,
	output logic             key_strobe_o
);
	import uio_pkg::*;

	byte_t      cmd;
	pay_cnt_t   pay_cnt;
	// byte lane of the current payload byte in a little-endian word
	logic [2:0] lane;
	// keyboard packet was given room in the FIFO
	logic       kbd_accept;
	logic       ext_r;
	logic       brk_r;
	logic       ext_cur;
	logic       brk_cur;
	logic       is_prefix;
	logic       first_pay;

	assign first_pay = (pay_cnt == pay_cnt_t'(1));
	assign lane      = 3'(pay_cnt - pay_cnt_t'(1));

	// prefix flags start fresh with each keyboard packet
	assign ext_cur   = first_pay ? 1'b0 : ext_r;
	assign brk_cur   = first_pay ? 1'b0 : brk_r;
	assign is_prefix = (byte_data_i == KBD_EXT) || (byte_data_i == KBD_BREAK);

	// status bit 0 holds the core, and with it the keyboard path, in reset
	assign kbd.flush = status_o[0];

	always_ff @(posedge clk_sys) begin
		key_strobe_o <= 1'b0;
		kbd.valid    <= 1'b0;
		if (xfer_end_i) begin
			pay_cnt    <= '0;
			kbd_accept <= 1'b0;
		end else if (byte_valid_i) begin
			if (pay_cnt != '1) begin
				pay_cnt <= pay_cnt + pay_cnt_t'(1);
			end
			if (pay_cnt == '0) begin
				cmd <= byte_data_i;
				// room is checked once, so a packet is forwarded whole or not at all
				kbd_accept <= (byte_data_i == CMD_KBD) && kbd.space_ok;
			end else begin
				case (cmd)
					CMD_BUT_SW: begin
						if (first_pay) begin
							buttons_o  <= byte_data_i[1:0];
							switches_o <= byte_data_i[3:2];
						end
					end
					CMD_JOY0: begin
						if (pay_cnt <= pay_cnt_t'(4)) begin
							joystick_0_o[{lane[1:0], 3'b000} +: 8] <= byte_data_i;
						end
					end
					CMD_JOY1: begin
						if (pay_cnt <= pay_cnt_t'(4)) begin
							joystick_1_o[{lane[1:0], 3'b000} +: 8] <= byte_data_i;
						end
					end
					CMD_STATUS64: begin
						if (pay_cnt <= pay_cnt_t'(8)) begin
							status_o[{lane, 3'b000} +: 8] <= byte_data_i;
						end
					end
					CMD_KBD: begin
						ext_r <= ext_cur | (byte_data_i == KBD_EXT);
						brk_r <= brk_cur | (byte_data_i == KBD_BREAK);
						// a non-prefix byte closes a key event
						if (!is_prefix) begin
							key_code_o     <= byte_data_i;
							key_extended_o <= ext_cur;
							key_pressed_o  <= ~brk_cur;
							key_strobe_o   <= 1'b1;
						end
						// every byte goes to PS/2 as is, prefixes included
						if (kbd_accept) begin
							kbd.valid <= 1'b1;
							kbd.data  <= byte_data_i;
						end
					end
					default: begin
						// unknown commands are ignored
					end
				endcase
			end
		end
	end

endmodule

// ==== src/kbd_stream_if.sv ====
// keyboard byte stream from the command decoder into the PS/2 FIFO, with producer and consumer views
interface kbd_stream_if;
	import uio_pkg::*;

	byte_t data;
	logic  valid;
	logic  ready;
	// at least KBD_PKT_SPACE entries free
	logic  space_ok;
	// synchronous clear of the FIFO contents
	logic  flush;

	modport producer (
		output data,
		output valid,
		output flush,
		input  ready,
		input  space_ok
	);

	modport consumer (
		input  data,
		input  valid,
		input  flush,
		output ready,
		output space_ok
	);

endinterface

// ==== src/ps2_serializer.sv ====
// PS/2 keyboard transmitter, divides clk_sys into the PS/2 clock and sends 11-bit frames from the FIFO
module ps2_serializer (
	input  logic           clk_sys,
	input  logic           flush_i,
	input  uio_pkg::byte_t head_i,
	input  logic           head_valid_i,
	output logic           pop_o,
	output logic           ps2_clk_o,
	output logic           ps2_data_o
);
	import uio_pkg::*;

	logic [$clog2(PS2_CLK_DIV)-1:0] div_cnt;
	logic                           ps2_clk_r;
	logic                           half_done;
	logic                           rise_tick;
	ps2_state_t                     state;
	byte_t                          shift;
	logic [2:0]                     bit_cnt;
	logic                           parity;

	assign half_done = (div_cnt == $bits(div_cnt)'(PS2_CLK_DIV - 1));
	// the PS/2 clock is about to go high
	assign rise_tick = half_done && !ps2_clk_r;

	// next byte leaves the FIFO as its start bit goes out
	assign pop_o = rise_tick && (state == IDLE) && head_valid_i;

	// line stays quiet between frames
	assign ps2_clk_o = ps2_clk_r || (state == IDLE);

	always_ff @(posedge clk_sys) begin
		if (flush_i) begin
			div_cnt    <= '0;
			ps2_clk_r  <= 1'b1;
			state      <= IDLE;
			ps2_data_o <= 1'b1;
		end else begin
			div_cnt <= half_done ? '0 : div_cnt + 1'b1;
			if (half_done) begin
				ps2_clk_r <= ~ps2_clk_r;
			end
			// data moves on the rising PS/2 clock, the device samples on the falling one
			if (rise_tick) begin
				case (state)
					IDLE: begin
						ps2_data_o <= 1'b1;
						if (head_valid_i) begin
							shift      <= head_i;
							parity     <= 1'b1;
							bit_cnt    <= 3'd0;
							ps2_data_o <= 1'b0;
							state      <= DATA;
						end
					end
					DATA: begin
						ps2_data_o <= shift[0];
						shift      <= {1'b0, shift[7:1]};
						parity     <= parity ^ shift[0];
						bit_cnt    <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							state <= PARITY;
						end
					end
					PARITY: begin
						// odd parity over the data bits
						ps2_data_o <= parity;
						state      <= STOP;
					end
					STOP: begin
						ps2_data_o <= 1'b1;
						state      <= GAP;
					end
					default: begin
						// stop bit period ends here, one idle period follows
						state <= IDLE;
					end
				endcase
			end
		end
	end

endmodule

// ==== src/ps2_tx_fifo.sv ====
// 16-entry keyboard byte FIFO between the command decoder and the PS/2 transmitter
module ps2_tx_fifo (
	input  logic           clk_sys,
	kbd_stream_if.consumer kbd,
	input  logic           pop_i,
	output uio_pkg::byte_t head_o,
	output logic           head_valid_o
);
	import uio_pkg::*;

	byte_t                    kbd_mem [KBD_FIFO_DEPTH];
	logic [KBD_FIFO_BITS-1:0] wptr;
	logic [KBD_FIFO_BITS-1:0] rptr;
	logic [KBD_FIFO_BITS:0]   count;
	logic                     push;
	logic                     pop;

	assign kbd.ready    = (count != (KBD_FIFO_BITS + 1)'(KBD_FIFO_DEPTH));
	assign kbd.space_ok = (count <= (KBD_FIFO_BITS + 1)'(KBD_FIFO_DEPTH - KBD_PKT_SPACE));
	assign head_valid_o = (count != '0);
	assign head_o       = kbd_mem[rptr];

	assign push = kbd.valid && kbd.ready;
	assign pop  = pop_i && head_valid_o;

	// flush empties the buffer, old entries are simply overwritten later
	always_ff @(posedge clk_sys) begin
		if (kbd.flush) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wptr <= wptr + 1'b1;
			end
			if (pop) begin
				rptr <= rptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push) begin
			kbd_mem[wptr] <= kbd.data;
		end
	end

endmodule

// ==== src/spi_byte_rx.sv ====
// SPI clock domain receiver, assembles MOSI bytes, flags each byte with a toggle and returns the core type
module spi_byte_rx (
	input  logic           SPI_CLK,
	input  logic           SPI_SS_IO,
	input  logic           SPI_MOSI,
	output uio_pkg::byte_t rx_byte_o,
	output logic           rx_toggle_o,
	output logic           xfer_idle_o,
	output logic           miso_o
);
	import uio_pkg::*;

	logic [2:0] bit_cnt;
	logic [6:0] sbuf;
	// set until the command byte has been received
	logic       first_byte;

	// bit counting and byte completion, cleared while the select is high
	always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt     <= 3'd0;
			first_byte  <= 1'b1;
			rx_toggle_o <= 1'b0;
			xfer_idle_o <= 1'b1;
		end else begin
			xfer_idle_o <= 1'b0;
			bit_cnt     <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				rx_toggle_o <= ~rx_toggle_o;
				first_byte  <= 1'b0;
			end
		end
	end

	// shift register and byte hold
	always_ff @(posedge SPI_CLK) begin
		if (bit_cnt == 3'd7) begin
			rx_byte_o <= {sbuf, SPI_MOSI};
		end else begin
			sbuf <= {sbuf[5:0], SPI_MOSI};
		end
	end

	// response changes on falling SPI_CLK so the controller samples on the rising edge
	// bit_cnt already points at the next bit here, MSB first
	always_ff @(negedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			miso_o <= CORE_TYPE[7];
		end else begin
			miso_o <= first_byte & CORE_TYPE[~bit_cnt];
		end
	end

endmodule

// ==== src/spi_sys_sync.sv ====
// brings the SPI byte toggle and transfer state into clk_sys as one-cycle byte events and an end level
module spi_sys_sync (
	input  logic           clk_sys,
	input  logic           SPI_SS_IO,
	input  logic           rx_toggle_i,
	input  logic           xfer_idle_i,
	input  uio_pkg::byte_t rx_byte_i,
	output logic           byte_valid_o,
	output uio_pkg::byte_t byte_data_o,
	output logic           xfer_end_o
);
	import uio_pkg::*;

	logic tog_meta;
	logic tog_sync;
	logic tog_prev;
	logic idle_meta;
	logic idle_sync;
	logic tog_edge;

	assign tog_edge = tog_sync ^ tog_prev;

	// two-flop synchronizers, the idle path is delayed to match the byte event
	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			tog_meta     <= 1'b0;
			tog_sync     <= 1'b0;
			tog_prev     <= 1'b0;
			idle_meta    <= 1'b1;
			idle_sync    <= 1'b1;
			byte_valid_o <= 1'b0;
			xfer_end_o   <= 1'b1;
		end else begin
			tog_meta     <= rx_toggle_i;
			tog_sync     <= tog_meta;
			tog_prev     <= tog_sync;
			idle_meta    <= xfer_idle_i;
			idle_sync    <= idle_meta;
			byte_valid_o <= tog_edge;
			xfer_end_o   <= idle_sync;
		end
	end

	// rx_byte stays put for a whole SPI byte after the toggle, so it is safe to take here
	always_ff @(posedge clk_sys) begin
		if (tog_edge) begin
			byte_data_o <= rx_byte_i;
		end
	end

endmodule

// ==== src/uio_pkg.sv ====
// shared types, command codes and sizing constants for the host-link receiver, imported by every block
package uio_pkg;

	// data widths with a meaning of their own
	typedef logic [7:0]  byte_t;
	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;

	// payload byte index, saturates at 15
	typedef logic [3:0]  pay_cnt_t;

	// command codes sent by the I/O controller
	localparam byte_t CMD_BUT_SW   = 8'h01;
	localparam byte_t CMD_KBD      = 8'h05;
	localparam byte_t CMD_JOY0     = 8'h60;
	localparam byte_t CMD_JOY1     = 8'h61;
	localparam byte_t CMD_STATUS64 = 8'h1e;

	// returned on MISO during every command byte
	localparam byte_t CORE_TYPE = 8'ha4;

	// keyboard scan code prefixes
	localparam byte_t KBD_EXT   = 8'he0;
	localparam byte_t KBD_BREAK = 8'hf0;

	// keyboard FIFO sizing
	localparam int KBD_FIFO_BITS  = 4;
	localparam int KBD_FIFO_DEPTH = 1 << KBD_FIFO_BITS;
	// room needed before a keyboard packet is taken
	localparam int KBD_PKT_SPACE  = 4;

	// clk_sys cycles per PS/2 half period
	localparam int PS2_CLK_DIV = 8;

	typedef enum logic [2:0] {
		IDLE,
		DATA,
		PARITY,
		STOP,
		GAP
	} ps2_state_t;

endpackage

// ==== src/user_io_top.sv ====
// top level of the host-link receiver, connects the SPI front end, command decoder and PS/2 keyboard path
module user_io_top (
	input  logic             clk_sys,
	input  logic             SPI_CLK,
	input  logic             SPI_SS_IO,
	input  logic             SPI_MOSI,
	output logic             SPI_MISO_o,
	output logic [1:0]       buttons_o,
	output logic [1:0]       switches_o,
	output uio_pkg::joy_t    joystick_0_o,
	output uio_pkg::joy_t    joystick_1_o,
	output uio_pkg::status_t status_o,
	output uio_pkg::byte_t   key_code_o,
	output logic             key_pressed_o,
	output logic             key_extended_o,
	output logic             key_strobe_o,
	output logic             ps2_kbd_clk_o,
	output logic             ps2_kbd_data_o
);
	import uio_pkg::*;

	byte_t rx_byte;
	logic  rx_toggle;
	logic  xfer_idle;
	logic  byte_valid;
	byte_t byte_data;
	logic  xfer_end;
	byte_t fifo_head;
	logic  fifo_head_valid;
	logic  fifo_pop;

	kbd_stream_if kbd_if ();

	spi_byte_rx u_spi_byte_rx (
		.SPI_CLK     (SPI_CLK),
		.SPI_SS_IO   (SPI_SS_IO),
		.SPI_MOSI    (SPI_MOSI),
		.rx_byte_o   (rx_byte),
		.rx_toggle_o (rx_toggle),
		.xfer_idle_o (xfer_idle),
		.miso_o      (SPI_MISO_o)
	);

	spi_sys_sync u_spi_sys_sync (
		.clk_sys      (clk_sys),
		.SPI_SS_IO    (SPI_SS_IO),
		.rx_toggle_i  (rx_toggle),
		.xfer_idle_i  (xfer_idle),
		.rx_byte_i    (rx_byte),
		.byte_valid_o (byte_valid),
		.byte_data_o  (byte_data),
		.xfer_end_o   (xfer_end)
	);

	host_cmd_decoder u_host_cmd_decoder (
		.clk_sys        (clk_sys),
		.byte_valid_i   (byte_valid),
		.byte_data_i    (byte_data),
		.xfer_end_i     (xfer_end),
		.kbd            (kbd_if.producer),
		.buttons_o      (buttons_o),
		.switches_o     (switches_o),
		.joystick_0_o   (joystick_0_o),
		.joystick_1_o   (joystick_1_o),
		.status_o       (status_o),
		.key_code_o     (key_code_o),
		.key_pressed_o  (key_pressed_o),
		.key_extended_o (key_extended_o),
		.key_strobe_o   (key_strobe_o)
	);

	ps2_tx_fifo u_ps2_tx_fifo (
		.clk_sys      (clk_sys),
		.kbd          (kbd_if.consumer),
		.pop_i        (fifo_pop),
		.head_o       (fifo_head),
		.head_valid_o (fifo_head_valid)
	);

	// core reset from the controller also stops a frame in flight
	ps2_serializer u_ps2_serializer (
		.clk_sys      (clk_sys),
		.flush_i      (status_o[0]),
		.head_i       (fifo_head),
		.head_valid_i (fifo_head_valid),
		.pop_o        (fifo_pop),
		.ps2_clk_o    (ps2_kbd_clk_o),
		.ps2_data_o   (ps2_kbd_data_o)
	);

endmodule
